/* logic/id_defs.svh */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32
`define ALU_OP_W    12
`define LINK_REG    1       // bl writes its return address here
`define PC_STEP     4

// major opcode, inst[31:26]
`define OP_ALU       6'h00
`define OP_LU12I     6'h05
`define OP_PCADDU12I 6'h07
`define OP_MEM       6'h0a
`define OP_JIRL      6'h13
`define OP_B         6'h14
`define OP_BL        6'h15
`define OP_BEQ       6'h16
`define OP_BNE       6'h17
`define OP_BLT       6'h18
`define OP_BGE       6'h19
`define OP_BLTU      6'h1a
`define OP_BGEU      6'h1b

`endif

/* logic/id_pkg.sv */
`include "id_defs.svh"

package id_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;  // add sub slt sltu and nor or xor sll srl sra lui

    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_write_t;

    // one producer in a later stage, EXE or MEM
    typedef struct packed {
        logic      valid;
        logic      we;
        logic      is_load;
        reg_addr_t dest;
        word_t     result;
    } fwd_src_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        logic      mem_byte;
        logic      mem_half;
        logic      mem_unsigned;
        reg_addr_t dest;
        logic      src2_is_rd;      // second read port takes rd instead of rk
        logic      br_beq;
        logic      br_bne;
        logic      br_blt;
        logic      br_bge;
        logic      br_bltu;
        logic      br_bgeu;
        logic      br_jirl;
        logic      br_direct;       // b and bl
        word_t     imm;
        word_t     br_offs;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        logic      mem_byte;
        logic      mem_half;
        logic      mem_unsigned;
        reg_addr_t dest;
        word_t     imm;
        word_t     pc;
        word_t     rj_value;
        word_t     rkd_value;
    } id_exe_t;

    typedef struct packed {
        logic  stall;
        logic  taken;
        word_t target;
    } br_t;

endpackage

/* logic/inst_decoder.sv */
`include "id_defs.svh"

module inst_decoder (
    input  id_pkg::word_t     inst,
    output id_pkg::dec_ctrl_t ctrl
);
    import id_pkg::*;

    logic [ 5:0] op_31_26;
    logic [ 3:0] op_25_22;
    logic [ 1:0] op_21_20;
    logic [ 4:0] op_19_15;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        is_3r, is_shift_imm, is_alu_op;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
    logic        inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic        inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w;
    logic        inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic        inst_lu12i_w, inst_pcaddu12i;
    logic        inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic        inst_st_b, inst_st_h, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl;
    logic        inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic        is_load, is_store, is_cond_br, is_link;
    logic        need_si20, need_ui12, need_si26;
    alu_op_t     alu_op;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign i12      = inst[21:10];
    assign i16      = inst[25:10];
    assign i20      = inst[24:5];
    assign i26      = {inst[9:0], inst[25:10]};

    // ============================================================
    // instruction match
    assign is_alu_op    = (op_31_26 == `OP_ALU);
    assign is_3r        = is_alu_op && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_shift_imm = is_alu_op && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w     = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w     = is_3r && (op_19_15 == 5'h02);
    assign inst_slt       = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu      = is_3r && (op_19_15 == 5'h05);
    assign inst_nor       = is_3r && (op_19_15 == 5'h08);
    assign inst_and       = is_3r && (op_19_15 == 5'h09);
    assign inst_or        = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor       = is_3r && (op_19_15 == 5'h0b);
    assign inst_sll_w     = is_3r && (op_19_15 == 5'h0e);
    assign inst_srl_w     = is_3r && (op_19_15 == 5'h0f);
    assign inst_sra_w     = is_3r && (op_19_15 == 5'h10);
    assign inst_slli_w    = is_shift_imm && (op_19_15 == 5'h01);
    assign inst_srli_w    = is_shift_imm && (op_19_15 == 5'h09);
    assign inst_srai_w    = is_shift_imm && (op_19_15 == 5'h11);
    assign inst_slti      = is_alu_op && (op_25_22 == 4'h8);
    assign inst_sltui     = is_alu_op && (op_25_22 == 4'h9);
    assign inst_addi_w    = is_alu_op && (op_25_22 == 4'ha);
    assign inst_andi      = is_alu_op && (op_25_22 == 4'hd);
    assign inst_ori       = is_alu_op && (op_25_22 == 4'he);
    assign inst_xori      = is_alu_op && (op_25_22 == 4'hf);
    assign inst_lu12i_w   = (op_31_26 == `OP_LU12I) && !inst[25];
    assign inst_pcaddu12i = (op_31_26 == `OP_PCADDU12I) && !inst[25];
    assign inst_ld_b      = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h0);
    assign inst_ld_h      = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h1);
    assign inst_ld_w      = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h2);
    assign inst_st_b      = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h4);
    assign inst_st_h      = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h5);
    assign inst_st_w      = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h6);
    assign inst_ld_bu     = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h8);
    assign inst_ld_hu     = (op_31_26 == `OP_MEM) && (op_25_22 == 4'h9);
    assign inst_jirl      = (op_31_26 == `OP_JIRL);
    assign inst_b         = (op_31_26 == `OP_B);
    assign inst_bl        = (op_31_26 == `OP_BL);
    assign inst_beq       = (op_31_26 == `OP_BEQ);
    assign inst_bne       = (op_31_26 == `OP_BNE);
    assign inst_blt       = (op_31_26 == `OP_BLT);
    assign inst_bge       = (op_31_26 == `OP_BGE);
    assign inst_bltu      = (op_31_26 == `OP_BLTU);
    assign inst_bgeu      = (op_31_26 == `OP_BGEU);

    assign is_load    = inst_ld_b || inst_ld_h || inst_ld_w || inst_ld_bu || inst_ld_hu;
    assign is_store   = inst_st_b || inst_st_h || inst_st_w;
    assign is_cond_br = inst_beq || inst_bne || inst_blt || inst_bge || inst_bltu || inst_bgeu;
    assign is_link    = inst_jirl || inst_bl;   // alu computes pc + 4
    assign need_si20  = inst_lu12i_w || inst_pcaddu12i;
    assign need_ui12  = inst_andi || inst_ori || inst_xori;
    assign need_si26  = inst_b || inst_bl;

    // ============================================================
    // control fields
    assign alu_op[0]  = inst_add_w || inst_addi_w || is_load || is_store || is_link
                        || inst_pcaddu12i;
    assign alu_op[1]  = inst_sub_w;
    assign alu_op[2]  = inst_slt || inst_slti;
    assign alu_op[3]  = inst_sltu || inst_sltui;
    assign alu_op[4]  = inst_and || inst_andi;
    assign alu_op[5]  = inst_nor;
    assign alu_op[6]  = inst_or || inst_ori;
    assign alu_op[7]  = inst_xor || inst_xori;
    assign alu_op[8]  = inst_sll_w || inst_slli_w;
    assign alu_op[9]  = inst_srl_w || inst_srli_w;
    assign alu_op[10] = inst_sra_w || inst_srai_w;
    assign alu_op[11] = inst_lu12i_w;

    always_comb begin
        ctrl.alu_op       = alu_op;
        ctrl.src1_is_pc   = is_link || inst_pcaddu12i;
        ctrl.src2_is_imm  = is_shift_imm || inst_addi_w || inst_slti || inst_sltui || need_ui12
                            || need_si20 || is_load || is_store || is_link;
        ctrl.res_from_mem = is_load;
        ctrl.gr_we        = (|alu_op) && !is_store;  // zero for unknown encodings
        ctrl.mem_we       = is_store;
        ctrl.mem_byte     = inst_ld_b || inst_ld_bu || inst_st_b;
        ctrl.mem_half     = inst_ld_h || inst_ld_hu || inst_st_h;
        ctrl.mem_unsigned = inst_ld_bu || inst_ld_hu;
        ctrl.dest         = inst_bl ? reg_addr_t'(`LINK_REG) : inst[4:0];
        ctrl.src2_is_rd   = is_cond_br || is_store;
        ctrl.br_beq       = inst_beq;
        ctrl.br_bne       = inst_bne;
        ctrl.br_blt       = inst_blt;
        ctrl.br_bge       = inst_bge;
        ctrl.br_bltu      = inst_bltu;
        ctrl.br_bgeu      = inst_bgeu;
        ctrl.br_jirl      = inst_jirl;
        ctrl.br_direct    = need_si26;
        ctrl.imm          = is_link   ? word_t'(`PC_STEP) :
                            need_si20 ? {i20, 12'b0} :
                            need_ui12 ? {20'b0, i12} :
                                        {{20{i12[11]}}, i12};
        ctrl.br_offs      = need_si26 ? {{4{i26[25]}}, i26, 2'b0} :
                                        {{14{i16[15]}}, i16, 2'b0};
    end

endmodule

/* logic/regfile.sv */
`include "id_defs.svh"

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::wb_write_t wr
);
    import id_pkg::*;

    word_t rf [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            rf[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired to zero on both read ports
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* logic/operand_bypass.sv */
module operand_bypass (
    input  id_pkg::reg_addr_t raddr,
    input  logic              used,
    input  id_pkg::word_t     rf_data,
    input  id_pkg::fwd_src_t  exe_fwd,
    input  id_pkg::fwd_src_t  mem_fwd,
    input  id_pkg::wb_write_t wb,
    output id_pkg::word_t     value,
    output logic              load_hazard
);

    logic src_zero;
    logic exe_hit;
    logic mem_hit;
    logic wb_hit;

    assign src_zero = (raddr == '0);

    assign exe_hit = exe_fwd.valid && exe_fwd.we && (exe_fwd.dest == raddr);
    assign mem_hit = mem_fwd.valid && mem_fwd.we && (mem_fwd.dest == raddr);
    assign wb_hit  = wb.we && (wb.addr == raddr);

    // youngest producer wins
    always_comb begin
        if (src_zero) begin
            value = '0;
        end else if (exe_hit) begin
            value = exe_fwd.result;
        end else if (mem_hit) begin
            value = mem_fwd.result;
        end else if (wb_hit) begin
            value = wb.data;
        end else begin
            value = rf_data;
        end
    end

    // load data is not there until MEM
    assign load_hazard = used && !src_zero && exe_hit && exe_fwd.is_load;

endmodule

/* logic/branch_unit.sv */
module branch_unit (
    input  id_pkg::dec_ctrl_t ctrl,
    input  id_pkg::word_t     pc,
    input  id_pkg::word_t     rj_value,
    input  id_pkg::word_t     rkd_value,
    output logic              taken_cond,
    output id_pkg::word_t     target
);
    import id_pkg::*;

    logic  rj_eq_rkd;
    logic  rj_lt_rkd;
    logic  rj_ltu_rkd;
    word_t base;

    assign rj_eq_rkd  = (rj_value == rkd_value);
    assign rj_lt_rkd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rkd = (rj_value < rkd_value);

    assign taken_cond = (ctrl.br_beq  &&  rj_eq_rkd)
                     || (ctrl.br_bne  && !rj_eq_rkd)
                     || (ctrl.br_blt  &&  rj_lt_rkd)
                     || (ctrl.br_bge  && !rj_lt_rkd)
                     || (ctrl.br_bltu &&  rj_ltu_rkd)
                     || (ctrl.br_bgeu && !rj_ltu_rkd)
                     || ctrl.br_jirl
                     || ctrl.br_direct;

    // jirl is register relative, everything else pc relative
    assign base   = ctrl.br_jirl ? rj_value : pc;
    assign target = base + ctrl.br_offs;

endmodule

/* logic/id_stage.sv */
module id_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              if_to_id_valid,
    input  id_pkg::if_id_t    if_to_id_bus,
    output logic              id_allowin,
    input  logic              exe_allowin,
    output logic              id_to_exe_valid,
    output id_pkg::id_exe_t   id_to_exe_bus,
    output id_pkg::br_t       br_bus,
    input  id_pkg::wb_write_t wb_bus,
    input  id_pkg::fwd_src_t  exe_fwd,
    input  id_pkg::fwd_src_t  mem_fwd
);
    import id_pkg::*;

    logic      id_valid;
    if_id_t    id_inst;
    dec_ctrl_t ctrl;
    logic      ready_go;
    logic      br_taken;
    logic      taken_cond;
    logic      is_cond_br;
    logic      rj_used;
    logic      rkd_used;
    logic      rj_hazard;
    logic      rkd_hazard;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rj_value;
    word_t     rkd_value;
    word_t     br_target;

    // ============================================================
    // handshake and stage valid
    assign ready_go        = !(rj_hazard || rkd_hazard);
    assign id_allowin      = !id_valid || (ready_go && exe_allowin);
    assign id_to_exe_valid = id_valid && ready_go;
    assign br_taken        = id_valid && ready_go && taken_cond;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid && !br_taken;  // drop the wrong-path fetch
        end
    end

    always_ff @(posedge clk) begin
        if (id_allowin && if_to_id_valid) begin
            id_inst <= if_to_id_bus;
        end
    end

    inst_decoder u_decoder (
        .inst (id_inst.inst),
        .ctrl (ctrl)
    );

    // ============================================================
    // operands
    assign rf_raddr1 = id_inst.inst[9:5];
    assign rf_raddr2 = ctrl.src2_is_rd ? id_inst.inst[4:0] : id_inst.inst[14:10];

    assign is_cond_br = ctrl.br_beq || ctrl.br_bne || ctrl.br_blt || ctrl.br_bge
                        || ctrl.br_bltu || ctrl.br_bgeu;
    // lu12i, pcaddu12i and bl do not read rj
    assign rj_used  = is_cond_br
                      || ((|ctrl.alu_op) && !ctrl.alu_op[11]
                          && !(ctrl.src1_is_pc && !ctrl.br_jirl));
    assign rkd_used = ctrl.src2_is_rd || ((|ctrl.alu_op) && !ctrl.src2_is_imm);

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_bus)
    );

    operand_bypass u_rj_bypass (
        .raddr       (rf_raddr1),
        .used        (rj_used),
        .rf_data     (rf_rdata1),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb          (wb_bus),
        .value       (rj_value),
        .load_hazard (rj_hazard)
    );

    operand_bypass u_rkd_bypass (
        .raddr       (rf_raddr2),
        .used        (rkd_used),
        .rf_data     (rf_rdata2),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb          (wb_bus),
        .value       (rkd_value),
        .load_hazard (rkd_hazard)
    );

    branch_unit u_branch (
        .ctrl       (ctrl),
        .pc         (id_inst.pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .taken_cond (taken_cond),
        .target     (br_target)
    );

    // ============================================================
    // outputs
    always_comb begin
        id_to_exe_bus.alu_op       = ctrl.alu_op;
        id_to_exe_bus.src1_is_pc   = ctrl.src1_is_pc;
        id_to_exe_bus.src2_is_imm  = ctrl.src2_is_imm;
        id_to_exe_bus.res_from_mem = ctrl.res_from_mem;
        id_to_exe_bus.gr_we        = ctrl.gr_we;
        id_to_exe_bus.mem_we       = ctrl.mem_we;
        id_to_exe_bus.mem_byte     = ctrl.mem_byte;
        id_to_exe_bus.mem_half     = ctrl.mem_half;
        id_to_exe_bus.mem_unsigned = ctrl.mem_unsigned;
        id_to_exe_bus.dest         = ctrl.dest;
        id_to_exe_bus.imm          = ctrl.imm;
        id_to_exe_bus.pc           = id_inst.pc;
        id_to_exe_bus.rj_value     = rj_value;
        id_to_exe_bus.rkd_value    = rkd_value;
    end

    always_comb begin
        br_bus.stall  = id_valid && !ready_go;
        br_bus.taken  = br_taken;
        br_bus.target = br_target;
    end

endmodule

/* bench/id_stage_assertions.sv */
module id_stage_assertions (
    input logic            clk,
    input logic            reset,
    input logic            exe_allowin,
    input logic            id_to_exe_valid,
    input id_pkg::id_exe_t id_to_exe_bus,
    input id_pkg::br_t     br_bus
);
    timeunit 1ns;
    timeprecision 1ps;

    valid_vs_stall: assert property (@(posedge clk) disable iff (reset)
        !(id_to_exe_valid && br_bus.stall))
        else $error("id_to_exe_valid and br_bus.stall high together");

    taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
        br_bus.taken |-> id_to_exe_valid)
        else $error("br_bus.taken without id_to_exe_valid");

    // held bundle must not move under back-pressure
    hold_pc: assert property (@(posedge clk) disable iff (reset)
        (id_to_exe_valid && !exe_allowin) |=> $stable(id_to_exe_bus.pc))
        else $error("id_to_exe_bus.pc changed while held");

endmodule

bind id_stage id_stage_assertions u_assertions (
    .clk             (clk),
    .reset           (reset),
    .exe_allowin     (exe_allowin),
    .id_to_exe_valid (id_to_exe_valid),
    .id_to_exe_bus   (id_to_exe_bus),
    .br_bus          (br_bus)
);

/* bench/id_stage_tb.sv */
`include "id_defs.svh"

module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import id_pkg::*;

    typedef struct packed {
        logic      preload;
        word_t     pc;
        word_t     inst;
        fwd_src_t  exe;
        fwd_src_t  mem;
        wb_write_t wb;
        alu_op_t   alu_op;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        word_t     imm;
        word_t     rj;
        word_t     rkd;
        logic      taken;
        word_t     target;
        logic      stall;
    } trace_rec_t;

    logic       clk;
    logic       reset;
    logic       if_to_id_valid;
    if_id_t     if_to_id_bus;
    logic       id_allowin;
    logic       exe_allowin;
    logic       id_to_exe_valid;
    id_exe_t    id_to_exe_bus;
    br_t        br_bus;
    wb_write_t  wb_bus;
    fwd_src_t   exe_fwd;
    fwd_src_t   mem_fwd;

    trace_rec_t recs[$];
    logic       trace_loaded;
    logic [31:0] lfsr_state;

    id_stage DUT (.*);

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [39:0] actual,
                               input logic [39:0] expected);
        if (actual !== expected) begin
            $display("error: %s got %h expected %h", name, actual, expected);
            fail_run("mismatch on a DUT output");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drive_exe_allowin();
        lfsr_state  = lfsr_step(lfsr_state);
        exe_allowin = lfsr_state[0];
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // ============================================================
    // trace loading
    task automatic load_trace();
        integer      fd;
        string       line;
        trace_rec_t  r;
        logic [31:0] t_pc, t_inst, t_imm, t_rj, t_rkd, t_tgt, t_addr, t_data;
        logic [39:0] t_exe, t_mem;
        logic [37:0] t_wb;
        logic [11:0] t_alu;
        logic [4:0]  t_dest;
        logic [0:0]  t_gw, t_mw, t_tk, t_st;
        fd = $fopen("bench/id_trace.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the trace file bench/id_trace.txt");
        end
        while ($fgets(line, fd) != 0) begin
            r = '0;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "P") begin
                void'($sscanf(line, "P %h %h", t_addr, t_data));
                r.preload = 1'b1;
                r.wb      = {1'b1, t_addr[4:0], t_data};
            end else begin
                void'($sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              t_pc, t_inst, t_exe, t_mem, t_wb, t_alu, t_dest, t_gw,
                              t_mw, t_imm, t_rj, t_rkd, t_tk, t_tgt, t_st));
                r.pc = t_pc;
                r.inst = t_inst;
                r.exe = fwd_src_t'(t_exe);
                r.mem = fwd_src_t'(t_mem);
                r.wb = wb_write_t'(t_wb);
                r.alu_op = t_alu;
                r.dest = t_dest;
                r.gr_we = t_gw[0];
                r.mem_we = t_mw[0];
                r.imm = t_imm;
                r.rj = t_rj;
                r.rkd = t_rkd;
                r.taken = t_tk[0];
                r.target = t_tgt;
                r.stall = t_st[0];
            end
            recs.push_back(r);
        end
        $fclose(fd);
    endtask

    // ============================================================
    // one instruction from fetch to EXE
    task automatic run_inst(input trace_rec_t r);
        if_to_id_valid = 1'b1;
        if_to_id_bus   = {r.pc, r.inst};
        exe_fwd        = r.exe;
        mem_fwd        = r.mem;
        wb_bus         = r.wb;
        @(negedge clk);
        check_value("id_allowin", 40'(id_allowin), 40'(1));
        next_cycle();
        if_to_id_valid = r.taken;   // wrong-path fetch behind a taken branch
        if_to_id_bus   = {32'hbad00000, 32'h00100823};
        drive_exe_allowin();
        @(negedge clk);
        check_value("br_bus.stall", 40'(br_bus.stall), 40'(r.stall));
        if (r.stall) begin
            check_value("id_to_exe_valid", 40'(id_to_exe_valid), 40'(0));
            check_value("id_allowin", 40'(id_allowin), 40'(0));
            check_value("br_bus.taken", 40'(br_bus.taken), 40'(0));
            next_cycle();
            mem_fwd = exe_fwd;  // load moves on to MEM
            exe_fwd = '0;
            drive_exe_allowin();
            @(negedge clk);
            check_value("br_bus.stall", 40'(br_bus.stall), 40'(0));
        end
        check_value("id_to_exe_valid", 40'(id_to_exe_valid), 40'(1));
        while (!(id_to_exe_valid && exe_allowin)) begin
            check_value("id_allowin", 40'(id_allowin), 40'(0));  // held under back-pressure
            next_cycle();
            drive_exe_allowin();
            @(negedge clk);
        end
        check_value("id_to_exe_bus.pc", 40'(id_to_exe_bus.pc), 40'(r.pc));
        check_value("id_to_exe_bus.alu_op", 40'(id_to_exe_bus.alu_op), 40'(r.alu_op));
        check_value("id_to_exe_bus.dest", 40'(id_to_exe_bus.dest), 40'(r.dest));
        check_value("id_to_exe_bus.gr_we", 40'(id_to_exe_bus.gr_we), 40'(r.gr_we));
        check_value("id_to_exe_bus.mem_we", 40'(id_to_exe_bus.mem_we), 40'(r.mem_we));
        check_value("id_to_exe_bus.imm", 40'(id_to_exe_bus.imm), 40'(r.imm));
        check_value("id_to_exe_bus.rj_value", 40'(id_to_exe_bus.rj_value), 40'(r.rj));
        check_value("id_to_exe_bus.rkd_value", 40'(id_to_exe_bus.rkd_value), 40'(r.rkd));
        check_value("br_bus.taken", 40'(br_bus.taken), 40'(r.taken));
        if (r.taken) begin
            check_value("br_bus.target", 40'(br_bus.target), 40'(r.target));
        end
        next_cycle();
        if_to_id_valid = 1'b0;
        exe_fwd        = '0;
        mem_fwd        = '0;
        wb_bus         = '0;
        drive_exe_allowin();
        @(negedge clk);
        check_value("id_to_exe_valid", 40'(id_to_exe_valid), 40'(0));  // stage drained
    endtask

    initial begin
        wait (trace_loaded);
        #(recs.size() * 20 * 20);
        fail_run("timeout: the DUT did not finish the trace in time");
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        if_to_id_valid = 1'b0;
        if_to_id_bus   = '0;
        exe_allowin    = 1'b0;
        wb_bus         = '0;
        exe_fwd        = '0;
        mem_fwd        = '0;
        lfsr_state     = 32'hb08f;
        trace_loaded   = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_value("id_to_exe_valid", 40'(id_to_exe_valid), 40'(0));
        check_value("br_bus.taken", 40'(br_bus.taken), 40'(0));
        check_value("id_allowin", 40'(id_allowin), 40'(1));
        // clear the register file so every read is defined
        for (int i = 1; i < `REG_COUNT; i++) begin
            next_cycle();
            wb_bus = {1'b1, reg_addr_t'(i), 32'h0};
        end
        next_cycle();
        wb_bus = '0;
        foreach (recs[i]) begin
            if (recs[i].preload) begin
                wb_bus = recs[i].wb;
                next_cycle();
                wb_bus = '0;
            end else begin
                run_inst(recs[i]);
                next_cycle();
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* bench/id_trace.txt */
# P addr data : register preload through wb_bus
# I pc inst exe_fwd mem_fwd wb alu_op dest gr_we mem_we imm rj rkd taken target stall
P 01 00000010
P 02 00000020
P 03 fffffff0
P 04 00000010
P 05 80000000
I 1c000000 00100823 0000000000 0000000000 0000000000 001 03 1 0 00000402 00000010 00000020 0 00000000 0
I 1c000004 00110824 c100000111 c200000222 0000000000 002 04 1 0 00000442 00000111 00000222 0 00000000 0
I 1c000008 00150825 c100000111 c200000222 2200000333 040 05 1 0 00000542 00000111 00000222 0 00000000 0
I 1c00000c 001588e6 0000000000 0000000000 2700000444 080 06 1 0 00000562 00000444 00000333 0 00000000 0
I 1c000010 00100008 c000000555 0000000000 0000000000 001 08 1 0 00000400 00000000 00000000 0 00000000 0
I 1c000014 02bffc2a e100000666 0000000000 0000000000 001 0a 1 0 ffffffff 00000666 00000000 0 00000000 1
I 1c000018 2880104b 0000000000 0000000000 0000000000 001 0b 1 0 00000004 00000333 00000010 0 00000000 0
I 1c00001c 29bff023 0000000000 0000000000 0000000000 001 03 0 1 fffffffc 00000010 fffffff0 0 00000000 0
I 1c000020 142468ac 0000000000 0000000000 0000000000 800 0c 1 0 12345000 80000000 00000000 0 00000000 0
I 1c000024 0363fc4d 0000000000 0000000000 0000000000 010 0d 1 0 000008ff 00000333 00000000 0 00000000 0
I 1c000028 00408c2e 0000000000 0000000000 0000000000 100 0e 1 0 00000023 00000010 fffffff0 0 00000000 0
I 1c00002c 58004024 0000000000 0000000000 0000000000 000 04 0 0 00000010 00000010 00000010 1 1c00006c 0
I 1c000030 5c004024 0000000000 0000000000 0000000000 000 04 0 0 00000010 00000010 00000010 0 00000000 0
I 1c000034 63fff861 0000000000 0000000000 0000000000 000 01 0 0 fffffffe fffffff0 00000010 1 1c00002c 0
I 1c000038 6bfff861 0000000000 0000000000 0000000000 000 01 0 0 fffffffe fffffff0 00000010 0 00000000 0
I 1c00003c 64002023 0000000000 0000000000 0000000000 000 03 0 0 00000008 00000010 fffffff0 1 1c00005c 0
I 1c000040 6c002023 0000000000 0000000000 0000000000 000 03 0 0 00000008 00000010 fffffff0 0 00000000 0
I 1c000044 54040000 0000000000 0000000000 0000000000 001 01 1 0 00000004 00000000 00000000 1 1c000444 0
I 1c000048 53ffffff 0000000000 0000000000 0000000000 000 1f 0 0 ffffffff 00000000 00000000 1 1c000044 0
I 1c00004c 4c001041 0000000000 0000000000 0000000000 001 01 1 0 00000004 00000333 00000010 1 00000343 0
I 1c000050 4c001041 c200001000 0000000000 0000000000 001 01 1 0 00000004 00001000 00000010 1 00001010 0
I 1c000054 ffffffff 0000000000 0000000000 0000000000 000 1f 0 0 ffffffff 00000000 00000000 0 00000000 0
I 1c000058 58004024 e400000010 0000000000 0000000000 000 04 0 0 00000010 00000010 00000010 1 1c000098 1
I 1c00005c 0012046f 0000000000 0000000000 0000000000 004 0f 1 0 00000481 fffffff0 00000010 0 00000000 0
I 1c000060 001804b0 0000000000 c100000004 0000000000 400 10 1 0 00000601 80000000 00000004 0 00000000 0

/* loongarch_decode.f */
+incdir+logic
logic/id_pkg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
bench/id_stage_assertions.sv
bench/id_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
rm -f sim.log
( verilator --binary --timing --assert --top-module id_stage_tb \
    -f loongarch_decode.f -o sim_id_stage \
    && ./obj_dir/sim_id_stage ) > sim.log 2>&1 \
    || echo "simulation or build returned an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
